// ==== source/mem_sys_config.svh ====
`ifndef MEM_SYS_CONFIG_SVH
`define MEM_SYS_CONFIG_SVH

// memory subsystem sizing

// number of 64-bit words in the shared code/data RAM
// keep this a power of two, word indices wrap by truncation
`define MEM_WORDS 4096

// width of a core byte address
// rv64 core, so full 64 bits
`define ADDR_BITS 64

// derived values live in the packages
// mem_word_pkg turns MEM_WORDS into the word index width
// core_access_pkg turns ADDR_BITS into the address type

`endif

// ==== source/mem_word_pkg.sv ====
`default_nettype none

`include "mem_sys_config.svh"

// physical memory view: words, lane masks, indices
package mem_word_pkg;

  // one RAM word, 8 byte lanes
  typedef logic [63:0] word_t;

  // bit-level write mask, one bit per data bit of the word
  typedef logic [63:0] lane_mask_t;

  // index width follows the configured depth
  localparam int IDX_BITS = $clog2(`MEM_WORDS);

  // word index into the RAM array
  typedef logic [IDX_BITS-1:0] word_idx_t;

  // one 32-bit instruction, half a word
  typedef logic [31:0] inst_t;

endpackage

`default_nettype wire

// ==== source/core_access_pkg.sv ====
`default_nettype none

`include "mem_sys_config.svh"

// core-side view: what the core asks for and what it gets back
package core_access_pkg;

  // byte address as seen by the core
  typedef logic [`ADDR_BITS-1:0] addr_t;

  // access width of a load or store
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_dword
  } access_size_t;

  // instruction fetch, 4-byte aligned address
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // fetched instruction
  typedef struct packed {
    mem_word_pkg::inst_t inst;
  } fetch_rsp_t;

  // load or store request
  // wdata is right aligned, only the low size bytes matter
  typedef struct packed {
    addr_t               addr;
    access_size_t        size;
    logic                is_signed;
    logic                write;
    mem_word_pkg::word_t wdata;
  } data_req_t;

  // load result, already extended to 64 bits
  // don't care after a store
  typedef struct packed {
    mem_word_pkg::word_t rdata;
  } data_rsp_t;

endpackage

`default_nettype wire

// ==== source/ram_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_sys_config.svh"

// shared code/data RAM
// fetch port is read only, data port reads and does masked writes
module ram_mem (
  input  logic                     clk,
  input  logic                     inst_en,
  input  core_access_pkg::addr_t   inst_addr,
  output mem_word_pkg::inst_t      inst,
  input  logic                     data_en,
  input  logic                     data_write,
  input  mem_word_pkg::word_idx_t  data_idx,
  input  mem_word_pkg::lane_mask_t write_mask,
  input  mem_word_pkg::word_t      write_data,
  output mem_word_pkg::word_t      read_data
);

  // word array, no reset on contents
  mem_word_pkg::word_t mem [`MEM_WORDS];

  // fetch word index
  mem_word_pkg::word_idx_t inst_idx;

  // byte address >> 3, then keep only the low index bits
  // this is the modulo MEM_WORDS wrap
  assign inst_idx = inst_addr[3 +: mem_word_pkg::IDX_BITS];

  // fetch read, registered
  always_ff @(posedge clk) begin
    if (inst_en) begin
      // addr bit 2 picks the upper half
      if (inst_addr[2]) begin
        inst <= mem[inst_idx][63:32];
      end else begin
        inst <= mem[inst_idx][31:0];
      end
    end
  end

  // data port
  // read sees the old word, same for the fetch port above
  always_ff @(posedge clk) begin
    if (data_en) begin
      read_data <= mem[data_idx];
      if (data_write) begin
        // merge only the bits under the mask
        mem[data_idx] <= (mem[data_idx] & ~write_mask) | (write_data & write_mask);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/req_ack_port.sv ====
`timescale 1ns/1ns
`default_nettype none

// four-phase req/ack slave
// used for both the fetch and the data channel
module req_ack_port #(
  parameter type req_t = logic,
  parameter type rsp_t = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  req_t req_payload,
  output logic ack,
  output rsp_t rsp_payload,
  output logic start,
  output req_t cmd,
  input  rsp_t result
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_ack
  } state_t;

  state_t state;

  // control path
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        st_idle: begin
          // new request, kick the memory next cycle
          if (req) begin
            state <= st_wait;
            start <= 1'b1;
          end
        end
        st_wait: begin
          // memory registers its read while start is high
          // one cycle later the result is ready
          if (!start) begin
            state <= st_ack;
          end
        end
        st_ack: begin
          // hold until the core lets go
          if (!req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ack straight from the state register
  assign ack = (state == st_ack);

  // payload path
  always_ff @(posedge clk) begin
    // request held for the whole access
    if (state == st_idle && req) begin
      cmd <= req_payload;
    end
    // response held while ack is up
    if (state == st_wait && !start) begin
      rsp_payload <= result;
    end
  end

endmodule

`default_nettype wire

// ==== source/load_store_align.sv ====
`timescale 1ns/1ns
`default_nettype none

// byte lane handling for the data channel
// request side: index, mask, shifted store data
// response side: pick lanes out of the raw word and extend
module load_store_align (
  input  core_access_pkg::data_req_t cmd,
  output mem_word_pkg::word_idx_t    data_idx,
  output mem_word_pkg::lane_mask_t   write_mask,
  output mem_word_pkg::word_t        write_data,
  input  mem_word_pkg::word_t        raw_word,
  output core_access_pkg::data_rsp_t result
);

  // byte offset inside the word, truncated to the size
  logic [2:0] offset;
  // same offset in bits
  logic [5:0] bit_shift;
  // unshifted mask for the access width
  mem_word_pkg::lane_mask_t size_mask;
  // raw word with the addressed lanes moved to the bottom
  mem_word_pkg::word_t shifted_word;
  // extended load value
  mem_word_pkg::word_t load_value;

  // word index, wraps by truncation like the fetch side
  assign data_idx = cmd.addr[3 +: mem_word_pkg::IDX_BITS];

  // no misaligned support, low address bits just dropped
  always_comb begin
    case (cmd.size)
      core_access_pkg::size_byte: begin
        offset    = cmd.addr[2:0];
        size_mask = 64'h0000_0000_0000_00ff;
      end
      core_access_pkg::size_half: begin
        offset    = {cmd.addr[2:1], 1'b0};
        size_mask = 64'h0000_0000_0000_ffff;
      end
      core_access_pkg::size_word: begin
        offset    = {cmd.addr[2], 2'b00};
        size_mask = 64'h0000_0000_ffff_ffff;
      end
      default: begin
        // dword, always the whole word
        offset    = 3'b000;
        size_mask = '1;
      end
    endcase
  end

  assign bit_shift = {offset, 3'b000};

  // store side
  assign write_mask = size_mask << bit_shift;
  assign write_data = cmd.wdata << bit_shift;

  // load side
  assign shifted_word = raw_word >> bit_shift;

  always_comb begin
    case (cmd.size)
      core_access_pkg::size_byte:
        load_value = {{56{cmd.is_signed & shifted_word[7]}}, shifted_word[7:0]};
      core_access_pkg::size_half:
        load_value = {{48{cmd.is_signed & shifted_word[15]}}, shifted_word[15:0]};
      core_access_pkg::size_word:
        load_value = {{32{cmd.is_signed & shifted_word[31]}}, shifted_word[31:0]};
      // dword needs no extension
      default:
        load_value = shifted_word;
    endcase
  end

  assign result.rdata = load_value;

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

// memory subsystem top
// two handshake ports in front of one shared RAM
module mem_subsystem (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        fetch_req,
  input  core_access_pkg::fetch_req_t fetch_payload,
  output logic                        fetch_ack,
  output core_access_pkg::fetch_rsp_t fetch_rsp,
  input  logic                        data_req,
  input  core_access_pkg::data_req_t  data_payload,
  output logic                        data_ack,
  output core_access_pkg::data_rsp_t  data_rsp
);

  // fetch channel, port to RAM
  logic                        fetch_start;
  core_access_pkg::fetch_req_t fetch_cmd;
  core_access_pkg::fetch_rsp_t fetch_result;

  // data channel, port to aligner and RAM
  logic                       data_start;
  core_access_pkg::data_req_t data_cmd;
  core_access_pkg::data_rsp_t data_result;

  // aligner to RAM
  mem_word_pkg::word_idx_t  data_idx;
  mem_word_pkg::lane_mask_t write_mask;
  mem_word_pkg::word_t      write_data;
  mem_word_pkg::word_t      read_data;

  req_ack_port #(
    .req_t(core_access_pkg::fetch_req_t),
    .rsp_t(core_access_pkg::fetch_rsp_t)
  ) fetch_port_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (fetch_req),
    .req_payload(fetch_payload),
    .ack        (fetch_ack),
    .rsp_payload(fetch_rsp),
    .start      (fetch_start),
    .cmd        (fetch_cmd),
    .result     (fetch_result)
  );

  req_ack_port #(
    .req_t(core_access_pkg::data_req_t),
    .rsp_t(core_access_pkg::data_rsp_t)
  ) data_port_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (data_req),
    .req_payload(data_payload),
    .ack        (data_ack),
    .rsp_payload(data_rsp),
    .start      (data_start),
    .cmd        (data_cmd),
    .result     (data_result)
  );

  // combinational, cmd is held by the port
  load_store_align load_store_align_inst (
    .cmd       (data_cmd),
    .data_idx  (data_idx),
    .write_mask(write_mask),
    .write_data(write_data),
    .raw_word  (read_data),
    .result    (data_result)
  );

  // start pulses double as RAM enables
  ram_mem ram_mem_inst (
    .clk       (clk),
    .inst_en   (fetch_start),
    .inst_addr (fetch_cmd.addr),
    .inst      (fetch_result.inst),
    .data_en   (data_start),
    .data_write(data_cmd.write),
    .data_idx  (data_idx),
    .write_mask(write_mask),
    .write_data(write_data),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_sys_config.svh"

// table-driven testbench for the memory subsystem
module mem_subsystem_tb;

  localparam int k_fetch = 0;
  localparam int k_load = 1;
  localparam int k_store = 2;
  localparam int timeout_cycles = 50;
  localparam int byte_bits = $clog2(`MEM_WORDS) + 3;
  // byte span of the whole RAM, adding it gives an alias
  localparam logic [63:0] span = 64'(`MEM_WORDS) * 64'd8;
  localparam core_access_pkg::access_size_t sz_b = core_access_pkg::size_byte;
  localparam core_access_pkg::access_size_t sz_h = core_access_pkg::size_half;
  localparam core_access_pkg::access_size_t sz_w = core_access_pkg::size_word;
  localparam core_access_pkg::access_size_t sz_d = core_access_pkg::size_dword;

  // one stimulus row
  // use_ref takes the expected value from the byte model
  // hold keeps req high that many extra cycles after ack
  typedef struct {
    string                         name;
    int                            kind;
    logic [63:0]                   addr;
    core_access_pkg::access_size_t size;
    int                            sgn;
    mem_word_pkg::word_t           wdata;
    mem_word_pkg::word_t           expected;
    int                            use_ref;
    int                            hold;
  } row_t;

  logic clk;
  logic reset;
  logic fetch_req;
  core_access_pkg::fetch_req_t fetch_payload;
  logic fetch_ack;
  core_access_pkg::fetch_rsp_t fetch_rsp;
  logic data_req;
  core_access_pkg::data_req_t data_payload;
  logic data_ack;
  core_access_pkg::data_rsp_t data_rsp;

  row_t rows[$];
  // byte model of the RAM
  logic [7:0] ref_mem [`MEM_WORDS * 8];
  integer seed = 32'h927ba46a;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;

  mem_subsystem mem_subsystem_inst (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_payload(fetch_payload),
    .fetch_ack    (fetch_ack),
    .fetch_rsp    (fetch_rsp),
    .data_req     (data_req),
    .data_payload (data_payload),
    .data_ack     (data_ack),
    .data_rsp     (data_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // wrap to the RAM size, same as dropping high address bits
  function automatic logic [byte_bits-1:0] byte_index(input logic [63:0] addr);
    return addr[byte_bits-1:0];
  endfunction

  // offset truncated down to the access size
  function automatic logic [63:0] access_base(input logic [63:0] addr, input int nbytes);
    return addr & ~(64'(nbytes) - 64'd1);
  endfunction

  function automatic void ref_store(input logic [63:0] addr,
                                    input core_access_pkg::access_size_t size,
                                    input mem_word_pkg::word_t wdata);
    int nbytes;
    logic [63:0] base;
    nbytes = 1 << int'(size);
    base = access_base(addr, nbytes);
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[byte_index(base + 64'(i))] = wdata[8*i +: 8];
    end
  endfunction

  // little endian gather, then sign or zero extend
  function automatic mem_word_pkg::word_t ref_load(input logic [63:0] addr,
                                                   input core_access_pkg::access_size_t size,
                                                   input int sgn);
    int nbytes;
    logic [63:0] base;
    mem_word_pkg::word_t v;
    nbytes = 1 << int'(size);
    base = access_base(addr, nbytes);
    v = '0;
    for (int i = 0; i < nbytes; i++) begin
      v[8*i +: 8] = ref_mem[byte_index(base + 64'(i))];
    end
    if (sgn != 0 && nbytes < 8 && v[8*nbytes-1]) begin
      v = v | (~64'd0 << (8 * nbytes));
    end
    return v;
  endfunction

  task automatic check_inst(input string name, input mem_word_pkg::inst_t expected,
                            input mem_word_pkg::inst_t actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_load(input string name, input mem_word_pkg::word_t expected,
                            input mem_word_pkg::word_t actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic void add_row(input string name, input int kind, input logic [63:0] addr,
                                  input core_access_pkg::access_size_t size, input int sgn,
                                  input mem_word_pkg::word_t wdata,
                                  input mem_word_pkg::word_t expected,
                                  input int use_ref, input int hold);
    row_t r;
    r.name = name;
    r.kind = kind;
    r.addr = addr;
    r.size = size;
    r.sgn = sgn;
    r.wdata = wdata;
    r.expected = expected;
    r.use_ref = use_ref;
    r.hold = hold;
    rows.push_back(r);
  endfunction

  task automatic build_table();
    mem_word_pkg::word_t rnd_d;
    mem_word_pkg::word_t rnd_b;
    rnd_d = {$random(seed), $random(seed)};
    rnd_b = {$random(seed), $random(seed)};
    // full word round trip
    add_row("sd 0x100", k_store, 64'h100, sz_d, 0, 64'h0123_4567_89ab_cdef, '0, 0, 0);
    add_row("ld 0x100", k_load, 64'h100, sz_d, 0, '0, 64'h0123_4567_89ab_cdef, 0, 0);
    // partial stores merge into the word
    add_row("sb 0x101", k_store, 64'h101, sz_b, 0, 64'h5a, '0, 0, 0);
    add_row("sh 0x102", k_store, 64'h102, sz_h, 0, 64'hc0de, '0, 0, 0);
    add_row("sw 0x104", k_store, 64'h104, sz_w, 0, 64'hdead_beef, '0, 0, 0);
    add_row("ld merged", k_load, 64'h100, sz_d, 0, '0, 64'hdead_beef_c0de_5aef, 0, 0);
    // extension, word is now de ad be ef c0 de 5a ef
    add_row("lb neg", k_load, 64'h100, sz_b, 1, '0, 64'hffff_ffff_ffff_ffef, 0, 0);
    add_row("lbu neg", k_load, 64'h100, sz_b, 0, '0, 64'h0000_0000_0000_00ef, 0, 0);
    add_row("lb pos", k_load, 64'h101, sz_b, 1, '0, 64'h0000_0000_0000_005a, 0, 0);
    add_row("lh neg", k_load, 64'h102, sz_h, 1, '0, 64'hffff_ffff_ffff_c0de, 0, 0);
    // odd address truncates to 0x102
    add_row("lhu trunc", k_load, 64'h103, sz_h, 0, '0, 64'h0000_0000_0000_c0de, 0, 0);
    add_row("lw neg", k_load, 64'h104, sz_w, 1, '0, 64'hffff_ffff_dead_beef, 0, 0);
    add_row("lwu trunc", k_load, 64'h106, sz_w, 0, '0, 64'h0000_0000_dead_beef, 0, 0);
    add_row("lw low", k_load, 64'h100, sz_w, 1, '0, 64'hffff_ffff_c0de_5aef, 0, 0);
    // fetch halves
    add_row("fetch lo", k_fetch, 64'h100, sz_w, 0, '0, 64'hc0de_5aef, 0, 0);
    add_row("fetch hi", k_fetch, 64'h104, sz_w, 0, '0, 64'hdead_beef, 0, 0);
    // wrap beyond the RAM size
    add_row("ld alias", k_load, 64'h100 + span, sz_d, 0, '0, 64'hdead_beef_c0de_5aef, 0, 0);
    add_row("sd rnd alias", k_store, 64'h200 + 3 * span, sz_d, 0, rnd_d, '0, 0, 0);
    add_row("ld rnd", k_load, 64'h200, sz_d, 0, '0, '0, 1, 0);
    add_row("sb rnd alias", k_store, 64'h203 + span, sz_b, 0, rnd_b, '0, 0, 0);
    add_row("lb rnd", k_load, 64'h203, sz_b, 1, '0, '0, 1, 0);
    add_row("lhu rnd", k_load, 64'h202, sz_h, 0, '0, '0, 1, 0);
    add_row("fetch rnd", k_fetch, 64'h204 + 2 * span, sz_w, 0, '0, '0, 1, 0);
    add_row("ld rnd merged", k_load, 64'h200, sz_d, 0, '0, '0, 1, 0);
    // slow core, req held after ack
    add_row("ld held", k_load, 64'h100, sz_d, 0, '0, 64'hdead_beef_c0de_5aef, 0, 5);
    add_row("fetch held", k_fetch, 64'h104, sz_w, 0, '0, 64'hdead_beef, 0, 4);
  endtask

  // one four-phase transfer
  // outputs sampled on the falling edge, away from the DUT update
  task automatic run_access(input row_t r, output mem_word_pkg::inst_t got_inst,
                            output mem_word_pkg::word_t got_data);
    int cnt;
    logic ack_now;
    string held_name;
    @(posedge clk);
    if (r.kind == k_fetch) begin
      fetch_payload <= '{addr: r.addr};
      fetch_req <= 1'b1;
    end else begin
      data_payload <= '{addr: r.addr, size: r.size, is_signed: (r.sgn != 0),
                        write: (r.kind == k_store), wdata: r.wdata};
      data_req <= 1'b1;
    end
    // wait for ack to rise
    cnt = 0;
    ack_now = 1'b0;
    while (ack_now !== 1'b1 && cnt < timeout_cycles) begin
      @(negedge clk);
      ack_now = (r.kind == k_fetch) ? fetch_ack : data_ack;
      cnt++;
    end
    got_inst = fetch_rsp.inst;
    got_data = data_rsp.rdata;
    if (ack_now !== 1'b1) begin
      $display("%s: ack did not rise within %0d cycles", r.name, timeout_cycles);
      timeouts++;
      return;
    end
    // response must stay put while req is held
    held_name = {r.name, " held"};
    for (int i = 0; i < r.hold; i++) begin
      @(negedge clk);
      ack_now = (r.kind == k_fetch) ? fetch_ack : data_ack;
      if (ack_now !== 1'b1) begin
        $display("%s: ack dropped while req was still high", r.name);
        errors++;
      end
      if (r.kind == k_fetch) begin
        check_inst(held_name, got_inst, fetch_rsp.inst);
      end else begin
        check_load(held_name, got_data, data_rsp.rdata);
      end
    end
    @(posedge clk);
    fetch_req <= 1'b0;
    data_req <= 1'b0;
    // wait for ack to fall
    cnt = 0;
    while (ack_now !== 1'b0 && cnt < timeout_cycles) begin
      @(negedge clk);
      ack_now = (r.kind == k_fetch) ? fetch_ack : data_ack;
      cnt++;
    end
    if (ack_now !== 1'b0) begin
      $display("%s: ack did not fall within %0d cycles", r.name, timeout_cycles);
      timeouts++;
    end
  endtask

  initial begin
    row_t r;
    mem_word_pkg::inst_t got_inst;
    mem_word_pkg::word_t got_data;
    mem_word_pkg::word_t exp;
    reset = 1'b1;
    fetch_req = 1'b0;
    fetch_payload = '0;
    data_req = 1'b0;
    data_payload = '0;
    build_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (fetch_ack !== 1'b0 || data_ack !== 1'b0) begin
      $display("ack is not low right after reset");
      errors++;
    end
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (r.kind == k_store) begin
        ref_store(r.addr, r.size, r.wdata);
      end
      run_access(r, got_inst, got_data);
      if (timeouts != 0) begin
        break;
      end
      exp = (r.use_ref != 0) ? ref_load(r.addr, r.size, r.sgn) : r.expected;
      if (r.kind == k_fetch) begin
        check_inst(r.name, exp[31:0], got_inst);
      end else if (r.kind == k_load) begin
        check_load(r.name, exp, got_data);
      end
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_subsystem.f ====
+incdir+source
source/mem_word_pkg.sv
source/core_access_pkg.sv
source/ram_mem.sv
source/req_ack_port.sv
source/load_store_align.sv
source/mem_subsystem.sv
verification/mem_subsystem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = mem_subsystem_tb
FILELIST  = mem_subsystem.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run, echo the output and fail unless the pass line shows up
run: build
	@out=$$($(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
